//--- Makefile
TOP := executeTb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): sources.f $(wildcard hdl/*.sv) $(wildcard dv/*.sv)
	verilator --binary --timing --assert -f sources.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "FAIL: see errors above" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "PASS: all tests" sim.log; then \
		echo "Simulation ended without a result"; exit 1; \
	fi

lint:
	verilator --lint-only --timing --assert -Wall -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

//--- dv/executeTb.sv
`timescale 1ns/100ps
`default_nettype none

module executeTb import rvTypesPkg::*, rvIsaPkg::*; ();

    // About three times the cycles the tests need
    localparam int TIMEOUT_CYCLES = 400;

    logic       clk;
    logic       rstN;
    logic       instValid;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7b5;
    regIdx      rs1;
    regIdx      rs2;
    regIdx      rd;
    word        imm;
    word        pc;
    logic       resultValid;
    logic       illegalInst;
    word        resultData;
    regIdx      resultRd;
    logic       branchTaken;
    word        nextPc;

    // Reference model state and the outcome expected one cycle after issue
    word   shadow [32];
    word   curPc;
    int    cycleCount = 0;
    logic  pendValid;
    logic  pendLegal;
    logic  pendBranch;
    logic  pendTaken;
    word   pendData;
    regIdx pendRd;
    word   pendNext;

    executeTop uut (.*);

    bind executeTop executeTopAssertions protocolChecks (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $fatal(1, "timeout");
        end
    end

    task automatic reportError(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        $display("FAIL: see errors above");
        $fatal(1, "stopping at first error");
    endtask

    task automatic checkOutputs();
        if (!pendValid) begin
            assert (!resultValid && !illegalInst)
                else reportError("output pulse without an instruction");
        end else if (!pendLegal) begin
            assert (illegalInst && !resultValid)
                else reportError("illegal instruction not flagged");
        end else begin
            assert (resultValid && !illegalInst)
                else reportError("resultValid missing for a legal instruction");
            assert (resultData == pendData)
                else reportError($sformatf("resultData %h, expected %h", resultData, pendData));
            assert (resultRd == pendRd)
                else reportError($sformatf("resultRd %0d, expected %0d", resultRd, pendRd));
            assert (branchTaken == pendTaken)
                else reportError($sformatf("branchTaken %b, expected %b", branchTaken, pendTaken));
            if (pendBranch) begin
                assert (nextPc == pendNext)
                    else reportError($sformatf("nextPc %h, expected %h", nextPc, pendNext));
            end
        end
    endtask

    task automatic predictInst(input logic [6:0] opc, input logic [2:0] f3, input logic f7,
                               input regIdx s1, input regIdx s2, input regIdx d, input word im);
        word  a;
        word  b;
        word  y;
        logic ok;
        logic tk;
        a  = shadow[s1];
        b  = (opc == OPC_OPIMM) ? im : shadow[s2];
        y  = '0;
        ok = 1'b1;
        tk = 1'b0;
        if (opc == OPC_OP || opc == OPC_OPIMM) begin
            // funct7 bit 5 only for SUB and the arithmetic shifts
            if (f7 && f3 != F3_SRL && !(opc == OPC_OP && f3 == F3_ADD)) begin
                ok = 1'b0;
            end
            case (f3)
                F3_ADD:  y = (opc == OPC_OP && f7) ? a - b : a + b;
                F3_SLL:  y = a << b[4:0];
                F3_SLT:  y = {31'b0, $signed(a) < $signed(b)};
                F3_SLTU: y = {31'b0, a < b};
                F3_XOR:  y = a ^ b;
                F3_SRL: begin
                    if (f7) begin
                        y = $signed(a) >>> b[4:0];
                    end else begin
                        y = a >> b[4:0];
                    end
                end
                F3_OR:   y = a | b;
                default: y = a & b;
            endcase
        end else if (opc == OPC_BRANCH) begin
            case (f3)
                F3_BEQ:  tk = a == b;
                F3_BNE:  tk = a != b;
                F3_BLT:  tk = $signed(a) < $signed(b);
                F3_BGE:  tk = $signed(a) >= $signed(b);
                F3_BLTU: tk = a < b;
                F3_BGEU: tk = a >= b;
                default: ok = 1'b0;
            endcase
        end else begin
            ok = 1'b0;
        end
        pendValid  = 1'b1;
        pendLegal  = ok;
        pendBranch = opc == OPC_BRANCH;
        pendTaken  = pendBranch && tk;
        pendData   = pendBranch ? '0 : y;
        pendRd     = pendBranch ? '0 : d;
        pendNext   = tk ? curPc + im : curPc + 32'd4;
        if (ok && !pendBranch && d != 5'd0) begin
            shadow[d] = y;
        end
    endtask

    // Checks the previous instruction, then drives the next one
    task automatic issueInst(input logic [6:0] opc, input logic [2:0] f3, input logic f7,
                             input regIdx s1, input regIdx s2, input regIdx d, input word im);
        @(negedge clk);
        checkOutputs();
        instValid = 1'b1;
        opcode    = opc;
        funct3    = f3;
        funct7b5  = f7;
        rs1       = s1;
        rs2       = s2;
        rd        = d;
        imm       = im;
        pc        = curPc;
        predictInst(opc, f3, f7, s1, s2, d, im);
        curPc     = curPc + 32'd4;
    endtask

    task automatic idleCycle();
        @(negedge clk);
        checkOutputs();
        instValid = 1'b0;
        pendValid = 1'b0;
    endtask

    task automatic regOp(input logic [2:0] f3, input logic f7, input regIdx d,
                         input regIdx s1, input regIdx s2);
        issueInst(OPC_OP, f3, f7, s1, s2, d, $urandom);
    endtask

    task automatic immOp(input logic [2:0] f3, input logic f7, input regIdx d,
                         input regIdx s1, input word im);
        issueInst(OPC_OPIMM, f3, f7, s1, 5'($urandom), d, im);
    endtask

    task automatic condBranch(input logic [2:0] f3, input regIdx s1, input regIdx s2);
        word r;
        r = $urandom;
        // rd carries s1 so that a stray write would show up later
        issueInst(OPC_BRANCH, f3, 1'b0, s1, s2, s1, {{19{r[12]}}, r[12:1], 1'b0});
    endtask

    // Builds a full word from 10, 11 and 11 bit immediates
    task automatic loadReg(input regIdx d, input word v);
        immOp(F3_ADD, 1'b0, d, 5'd0, {22'b0, v[31:22]});
        immOp(F3_SLL, 1'b0, d, d, 32'd11);
        immOp(F3_OR, 1'b0, d, d, {21'b0, v[21:11]});
        immOp(F3_SLL, 1'b0, d, d, 32'd11);
        immOp(F3_OR, 1'b0, d, d, {21'b0, v[10:0]});
    endtask

    task automatic afterReset();
        regOp(F3_ADD, 1'b0, 5'd5, 5'd1, 5'd2);
        immOp(F3_ADD, 1'b0, 5'd3, 5'd0, 32'h0000_0123);
        immOp(F3_ADD, 1'b0, 5'd4, 5'd0, 32'hFFFF_F800);
        immOp(F3_ADD, 1'b0, 5'd0, 5'd0, 32'h0000_0055);
        regOp(F3_ADD, 1'b0, 5'd6, 5'd0, 5'd0);
        idleCycle();
    endtask

    task automatic randomRegOps();
        word va;
        word vb;
        for (int round = 0; round < 3; round++) begin
            va = $urandom;
            vb = $urandom;
            // First round sets SLT against SLTU and shifts by at least 16 for the sign fill
            if (round == 0) begin
                va[31] = 1'b1;
                vb[31] = 1'b0;
                vb[4]  = 1'b1;
            end
            loadReg(5'd1, va);
            loadReg(5'd2, vb);
            for (int f = 0; f < 8; f++) begin
                regOp(3'(f), 1'b0, 5'(10 + f), 5'd1, 5'd2);
            end
            regOp(F3_ADD, 1'b1, 5'd20, 5'd1, 5'd2);
            regOp(F3_SRL, 1'b1, 5'd21, 5'd1, 5'd2);
        end
        idleCycle();
    endtask

    task automatic immediateForms();
        loadReg(5'd7, 32'h8000_00F0);
        immOp(F3_SRL, 1'b0, 5'd8, 5'd7, 32'd4);
        immOp(F3_SRL, 1'b1, 5'd9, 5'd7, 32'd4);
        immOp(F3_SLTU, 1'b0, 5'd10, 5'd0, 32'd1);
        immOp(F3_SLTU, 1'b0, 5'd11, 5'd7, 32'd1);
        immOp(F3_SLT, 1'b0, 5'd12, 5'd7, 32'hFFFF_FFFF);
        immOp(F3_SLL, 1'b0, 5'd13, 5'd7, 32'd31);
        immOp(F3_XOR, 1'b0, 5'd14, 5'd7, 32'hFFFF_FFFF);
        immOp(F3_AND, 1'b0, 5'd15, 5'd7, 32'h0000_07FF);
        idleCycle();
    endtask

    task automatic branchSweep();
        logic [2:0] conds [6];
        conds = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        immOp(F3_ADD, 1'b0, 5'd14, 5'd0, 32'd5);
        immOp(F3_ADD, 1'b0, 5'd15, 5'd0, 32'hFFFF_FFFD);
        foreach (conds[i]) begin
            condBranch(conds[i], 5'd14, 5'd14);
            condBranch(conds[i], 5'd14, 5'd15);
            condBranch(conds[i], 5'd15, 5'd14);
        end
        regOp(F3_ADD, 1'b0, 5'd16, 5'd14, 5'd0);
        regOp(F3_ADD, 1'b0, 5'd17, 5'd15, 5'd0);
        idleCycle();
    endtask

    task automatic backToBack();
        immOp(F3_ADD, 1'b0, 5'd3, 5'd0, 32'd1);
        regOp(F3_ADD, 1'b0, 5'd3, 5'd3, 5'd3);
        regOp(F3_ADD, 1'b0, 5'd3, 5'd3, 5'd3);
        immOp(F3_SLL, 1'b0, 5'd3, 5'd3, 32'd2);
        regOp(F3_ADD, 1'b1, 5'd4, 5'd3, 5'd4);
        regOp(F3_XOR, 1'b0, 5'd3, 5'd4, 5'd3);
        idleCycle();
    endtask

    task automatic illegalEncodings();
        regOp(F3_XOR, 1'b1, 5'd7, 5'd1, 5'd2);
        immOp(F3_ADD, 1'b1, 5'd7, 5'd1, 32'd5);
        immOp(F3_SLL, 1'b1, 5'd7, 5'd1, 32'd3);
        issueInst(OPC_BRANCH, 3'b010, 1'b0, 5'd1, 5'd2, 5'd7, 32'd16);
        issueInst(7'b0000011, F3_ADD, 1'b0, 5'd1, 5'd2, 5'd7, 32'd8);
        regOp(F3_ADD, 1'b0, 5'd18, 5'd7, 5'd0);
        idleCycle();
    endtask

    initial begin
        void'($urandom(32'h2078_2344));
        clk        = 1'b0;
        rstN       = 1'b0;
        instValid  = 1'b0;
        opcode     = '0;
        funct3     = '0;
        funct7b5   = 1'b0;
        rs1        = '0;
        rs2        = '0;
        rd         = '0;
        imm        = '0;
        pc         = '0;
        curPc      = 32'h0000_1000;
        pendValid  = 1'b0;
        pendLegal  = 1'b0;
        pendBranch = 1'b0;
        pendTaken  = 1'b0;
        pendData   = '0;
        pendRd     = '0;
        pendNext   = '0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        afterReset();
        randomRegOps();
        immediateForms();
        branchSweep();
        backToBack();
        illegalEncodings();
        idleCycle();

        if (uut.protocolChecks.failures == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/executeTop_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module executeTopAssertions (
    input logic clk,
    input logic rstN,
    input logic instValid,
    input logic resultValid,
    input logic illegalInst,
    input logic branchTaken
);

    int failures = 0;

    // Result and illegal pulses exclude each other
    noDoublePulse: assert property (@(posedge clk) disable iff (!rstN)
        !(resultValid && illegalInst))
        else begin
            $error("resultValid and illegalInst high in the same cycle");
            failures++;
        end

    // Every pulse answers a strobe one cycle earlier
    pulseAfterStrobe: assert property (@(posedge clk) disable iff (!rstN)
        (resultValid || illegalInst) |-> $past(instValid))
        else begin
            $error("output pulse without instValid in the previous cycle");
            failures++;
        end

    takenOnlyWithResult: assert property (@(posedge clk) disable iff (!rstN)
        branchTaken |-> resultValid)
        else begin
            $error("branchTaken high without resultValid");
            failures++;
        end

endmodule

`default_nettype wire

//--- hdl/aluBus.sv
`timescale 1ns/100ps
`default_nettype none

interface aluBus import rvTypesPkg::*; ();

    // Result path
    aluOp  op;
    word   operandA;
    word   operandB;
    word   result;

    // Branch comparator path
    brCond cond;
    word   compareA;
    word   compareB;
    logic  taken;

    modport ctrl (
        output op, cond, operandA, operandB, compareA, compareB,
        input  result, taken
    );

    modport alu (
        input  op, cond, operandA, operandB, compareA, compareB,
        output result, taken
    );

endinterface

`default_nettype wire

//--- hdl/execControl.sv
`timescale 1ns/100ps
`default_nettype none

module execControl import rvTypesPkg::*, rvIsaPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       instValid,
    input  logic [6:0] opcode,
    input  logic [2:0] funct3,
    input  logic       funct7b5,
    input  regIdx      rd,
    input  word        imm,
    input  word        pc,
    input  word        readDataA,
    input  word        readDataB,
    aluBus.ctrl        bus,
    output logic       writeEn,
    output regIdx      writeAddr,
    output word        writeData,
    output logic       resultValid,
    output logic       illegalInst,
    output word        resultData,
    output regIdx      resultRd,
    output logic       branchTaken,
    output word        nextPc
);

    logic  isOp;
    logic  isOpImm;
    logic  isBranch;
    logic  aluLegal;
    logic  brLegal;
    logic  legal;
    aluOp  decodedOp;
    brCond decodedCond;
    word   branchTarget;
    word   seqPc;

    assign isOp     = opcode == OPC_OP;
    assign isOpImm  = opcode == OPC_OPIMM;
    assign isBranch = opcode == OPC_BRANCH;

    // funct7b5 is only legal for SUB and for SRA/SRAI
    always_comb begin
        decodedOp = ADD;
        aluLegal  = !funct7b5;
        case (funct3)
            F3_ADD: begin
                if (isOp && funct7b5) begin
                    decodedOp = SUB;
                end
                aluLegal = isOp || !funct7b5;
            end
            F3_SLL:  decodedOp = SLL;
            F3_SLT:  decodedOp = SLT;
            F3_SLTU: decodedOp = SLTU;
            F3_XOR:  decodedOp = XOR;
            F3_SRL: begin
                decodedOp = funct7b5 ? SRA : SRL;
                aluLegal  = 1'b1;
            end
            F3_OR:   decodedOp = OR;
            F3_AND:  decodedOp = AND;
            default: decodedOp = ADD;
        endcase
    end

    // Condition stays NONE outside BRANCH
    always_comb begin
        decodedCond = NONE;
        brLegal     = 1'b1;
        if (isBranch) begin
            case (funct3)
                F3_BEQ:  decodedCond = BEQ;
                F3_BNE:  decodedCond = BNE;
                F3_BLT:  decodedCond = BLT;
                F3_BGE:  decodedCond = BGE;
                F3_BLTU: decodedCond = BLTU;
                F3_BGEU: decodedCond = BGEU;
                default: brLegal = 1'b0;
            endcase
        end
    end

    assign legal = ((isOp || isOpImm) && aluLegal) || (isBranch && brLegal);

    // Operand steering
    assign bus.op       = decodedOp;
    assign bus.cond     = decodedCond;
    assign bus.operandA = readDataA;
    assign bus.operandB = isOpImm ? imm : readDataB;
    assign bus.compareA = readDataA;
    assign bus.compareB = readDataB;

    // Own adder for the target
    assign branchTarget = pc + imm;
    assign seqPc        = pc + 32'd4;

    // Register write lands on the edge that samples the instruction
    assign writeEn   = instValid && legal && !isBranch;
    assign writeAddr = rd;
    assign writeData = bus.result;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            resultValid <= 1'b0;
            illegalInst <= 1'b0;
            branchTaken <= 1'b0;
        end else begin
            resultValid <= instValid && legal;
            illegalInst <= instValid && !legal;
            branchTaken <= instValid && legal && isBranch && bus.taken;
        end
    end

    // Held until the next legal instruction
    always_ff @(posedge clk) begin
        if (instValid && legal) begin
            resultData <= isBranch ? '0 : bus.result;
            resultRd   <= isBranch ? '0 : rd;
            nextPc     <= bus.taken ? branchTarget : seqPc;
        end
    end

endmodule

`default_nettype wire

//--- hdl/executeTop.sv
`timescale 1ns/100ps
`default_nettype none

module executeTop import rvTypesPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       instValid,
    input  logic [6:0] opcode,
    input  logic [2:0] funct3,
    input  logic       funct7b5,
    input  regIdx      rs1,
    input  regIdx      rs2,
    input  regIdx      rd,
    input  word        imm,
    input  word        pc,
    output logic       resultValid,
    output logic       illegalInst,
    output word        resultData,
    output regIdx      resultRd,
    output logic       branchTaken,
    output word        nextPc
);

    word   readDataA;
    word   readDataB;
    logic  writeEn;
    regIdx writeAddr;
    word   writeData;

    aluBus bus ();

    // Source registers go straight to the read ports
    regFile uRegFile (
        .clk       (clk),
        .rstN      (rstN),
        .readAddrA (rs1),
        .readAddrB (rs2),
        .readDataA (readDataA),
        .readDataB (readDataB),
        .writeEn   (writeEn),
        .writeAddr (writeAddr),
        .writeData (writeData)
    );

    rvAlu uAlu (
        .bus (bus.alu)
    );

    execControl uCtrl (
        .clk         (clk),
        .rstN        (rstN),
        .instValid   (instValid),
        .opcode      (opcode),
        .funct3      (funct3),
        .funct7b5    (funct7b5),
        .rd          (rd),
        .imm         (imm),
        .pc          (pc),
        .readDataA   (readDataA),
        .readDataB   (readDataB),
        .bus         (bus.ctrl),
        .writeEn     (writeEn),
        .writeAddr   (writeAddr),
        .writeData   (writeData),
        .resultValid (resultValid),
        .illegalInst (illegalInst),
        .resultData  (resultData),
        .resultRd    (resultRd),
        .branchTaken (branchTaken),
        .nextPc      (nextPc)
    );

endmodule

`default_nettype wire

//--- hdl/regFile.sv
`timescale 1ns/100ps
`default_nettype none

module regFile import rvTypesPkg::*, rvIsaPkg::*; (
    input  logic  clk,
    input  logic  rstN,
    input  regIdx readAddrA,
    input  regIdx readAddrB,
    output word   readDataA,
    output word   readDataB,
    input  logic  writeEn,
    input  regIdx writeAddr,
    input  word   writeData
);

    word regs [REG_COUNT];

    // Entry 0 is never written, so x0 stays at its reset value of zero
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && (writeAddr != '0)) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Combinational reads
    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

endmodule

`default_nettype wire

//--- hdl/rvAlu.sv
`timescale 1ns/100ps
`default_nettype none

module rvAlu import rvTypesPkg::*, rvIsaPkg::*; (
    aluBus.alu bus
);

    logic [SHAMT_BITS-1:0] shamt;
    logic                  signedLess;
    logic                  unsignedLess;
    logic                  cmpEqual;
    logic                  cmpSignedLess;
    logic                  cmpUnsignedLess;

    // Only the low bits of operandB shift
    assign shamt = bus.operandB[SHAMT_BITS-1:0];

    assign signedLess   = $signed(bus.operandA) < $signed(bus.operandB);
    assign unsignedLess = bus.operandA < bus.operandB;

    always_comb begin
        case (bus.op)
            ADD:     bus.result = bus.operandA + bus.operandB;
            SUB:     bus.result = bus.operandA - bus.operandB;
            SLL:     bus.result = bus.operandA << shamt;
            SLT:     bus.result = word'(signedLess);
            // With operandB of 1 this sets on operandA equal to zero
            SLTU:    bus.result = word'(unsignedLess);
            XOR:     bus.result = bus.operandA ^ bus.operandB;
            SRL:     bus.result = bus.operandA >> shamt;
            // Sign fill from bit 31
            SRA:     bus.result = $signed(bus.operandA) >>> shamt;
            OR:      bus.result = bus.operandA | bus.operandB;
            AND:     bus.result = bus.operandA & bus.operandB;
            default: bus.result = '0;
        endcase
    end

    // Branch comparator, independent of the result path
    assign cmpEqual        = bus.compareA == bus.compareB;
    assign cmpSignedLess   = $signed(bus.compareA) < $signed(bus.compareB);
    assign cmpUnsignedLess = bus.compareA < bus.compareB;

    always_comb begin
        case (bus.cond)
            BEQ:     bus.taken = cmpEqual;
            BNE:     bus.taken = !cmpEqual;
            BLT:     bus.taken = cmpSignedLess;
            BGE:     bus.taken = !cmpSignedLess;
            BLTU:    bus.taken = cmpUnsignedLess;
            BGEU:    bus.taken = !cmpUnsignedLess;
            // NONE for every non-branch instruction
            default: bus.taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

    // Major opcodes handled by the stage
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // funct3 for OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct3 for BRANCH
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam int REG_COUNT  = 32;
    localparam int SHAMT_BITS = 5;

endpackage

`default_nettype wire

//--- hdl/rvTypesPkg.sv
`default_nettype none

package rvTypesPkg;

    // Data value and register number
    typedef logic [31:0] word;
    typedef logic [4:0]  regIdx;

    // Encoded as {funct7b5, funct3} of the OP form
    typedef enum logic [3:0] {
        ADD  = 4'b0000,
        SUB  = 4'b1000,
        SLL  = 4'b0001,
        SLT  = 4'b0010,
        SLTU = 4'b0011,
        XOR  = 4'b0100,
        SRL  = 4'b0101,
        SRA  = 4'b1101,
        OR   = 4'b0110,
        AND  = 4'b0111
    } aluOp;

    // Values follow the branch funct3
    // NONE sits in a slot that no branch uses
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        NONE = 3'b010,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } brCond;

endpackage

`default_nettype wire

//--- sources.f
hdl/rvTypesPkg.sv
hdl/rvIsaPkg.sv
hdl/aluBus.sv
hdl/regFile.sv
hdl/rvAlu.sv
hdl/execControl.sv
hdl/executeTop.sv
dv/executeTop_assertions.sv
dv/executeTb.sv
